/* build.f */
+incdir+hdl
hdl/panel_pkg.sv
hdl/panel_timing.sv
hdl/backlight_pwm.sv
hdl/home_button.sv
hdl/panel_output.sv
hdl/panel_top.sv
verif/panel_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile the panel testbench with Verilator and run it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module panel_tb -o panel_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/panel_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

/* verif/panel_tb.sv */
// ####################################################################
// Testbench for panel_top: geometry, color, syncs, backlight, button.
// ####################################################################
`timescale 1ns/1ps
`include "panel_settings.svh"

module panel_tb;

    localparam int FRAME_CLOCKS = 2 * `PANEL_H_TOTAL * `PANEL_V_TOTAL + 16;
    localparam int PWM_PERIOD   = `BACKLIGHT_PRESCALE * `BACKLIGHT_MAX;

    logic              clock_50;
    logic              reset_n;
    panel_pkg::color_t red = '0;
    panel_pkg::color_t green = '0;
    panel_pkg::color_t blue = '0;
    logic              hs_force;
    logic              vs_force;
    panel_pkg::level_t level;
    logic              level_valid;
    logic              button_pin;
    logic              button_ack;
    panel_pkg::coord_t lcd_x;
    panel_pkg::coord_t lcd_y;
    logic              next_frame;
    logic              lcd_clock;
    logic              lcd_de;
    logic              lcd_hs_n;
    logic              lcd_vs_n;
    logic              lcd_backlight;
    panel_pkg::color_t lcd_red;
    panel_pkg::color_t lcd_green;
    panel_pkg::color_t lcd_blue;
    logic              button_state;

    // Check enables and reference state, written by the stimulus.
    logic              geometry_on;
    logic              pwm_window;
    logic              button_check;
    logic              button_expect;
    panel_pkg::color_t red_q;
    panel_pkg::color_t green_q;
    panel_pkg::color_t blue_q;
    logic              force_q;
    logic              de_q;
    logic              hs_q;
    int                de_ticks;
    int                hs_ticks;
    int                vs_ticks;
    int                active_lines;
    int                high_count;

    panel_top u_dut (
        .clock_50 (clock_50), .reset_n (reset_n),
        .red (red), .green (green), .blue (blue),
        .hs_force (hs_force), .vs_force (vs_force),
        .level (level), .level_valid (level_valid),
        .button_pin (button_pin), .button_ack (button_ack),
        .lcd_x (lcd_x), .lcd_y (lcd_y), .next_frame (next_frame),
        .lcd_clock (lcd_clock), .lcd_de (lcd_de),
        .lcd_hs_n (lcd_hs_n), .lcd_vs_n (lcd_vs_n),
        .lcd_backlight (lcd_backlight),
        .lcd_red (lcd_red), .lcd_green (lcd_green), .lcd_blue (lcd_blue),
        .button_state (button_state)
    );

    initial begin
        clock_50 = 1'b0;
        forever #20 clock_50 = ~clock_50;
    end

    // Frame source model, a pattern taken from the scan position.
    always @(negedge clock_50) begin
        red   = lcd_x[7:0];
        green = ~lcd_x[7:0];
        blue  = lcd_y[7:0];
    end

    task automatic report_error(input string text);
        $display("%s", text);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_count(input string test, input int expected, input int actual);
        assert (actual == expected)
        else report_error($sformatf("Error: %s expected %0d actual %0d", test, expected, actual));
    endtask

    // Returns at the first clock of next_frame.
    task automatic wait_frame_start(input string test);
        int count;
        count = 0;
        while (next_frame || count == 0) begin
            if (count == FRAME_CLOCKS) begin
                report_error($sformatf("Timeout: next_frame stuck high in %s", test));
            end
            @(negedge clock_50);
            count++;
        end
        count = 0;
        while (!next_frame) begin
            if (count == FRAME_CLOCKS) begin
                report_error($sformatf("Timeout: no next_frame pulse in %s", test));
            end
            @(negedge clock_50);
            count++;
        end
    endtask

    task automatic wait_button(input logic expected, input int limit, input string test);
        int count;
        count = 0;
        while (button_state !== expected) begin
            if (count == limit) begin
                report_error($sformatf("Timeout: button_state not %0d after %0d clocks in %s",
                                       expected, limit, test));
            end
            @(negedge clock_50);
            count++;
        end
    endtask

    task automatic measure_backlight(input string test, input int expected);
        pwm_window = 1'b1;
        repeat (PWM_PERIOD) @(negedge clock_50);
        pwm_window = 1'b0;
        check_count(test, expected, high_count);
    endtask

    always @(posedge clock_50) begin
        red_q   <= red;
        green_q <= green;
        blue_q  <= blue;
        force_q <= hs_force & vs_force;
        de_q    <= lcd_de;
        hs_q    <= lcd_hs_n;
        // One count per pixel tick, using the delayed tick on lcd_clock.
        if (!geometry_on || !lcd_de) begin
            de_ticks <= 0;
        end else if (lcd_clock) begin
            de_ticks <= de_ticks + 1;
        end
        if (!geometry_on || lcd_hs_n) begin
            hs_ticks <= 0;
        end else if (lcd_clock) begin
            hs_ticks <= hs_ticks + 1;
        end
        // Vertical sync ticks summed over the whole frame.
        if (!geometry_on) begin
            vs_ticks <= 0;
        end else if (lcd_clock && !lcd_vs_n) begin
            vs_ticks <= vs_ticks + 1;
        end
        if (!geometry_on) begin
            active_lines <= 0;
        end else if (de_q && !lcd_de) begin
            active_lines <= active_lines + 1;
        end
        if (!pwm_window) begin
            high_count <= 0;
        end else if (lcd_backlight) begin
            high_count <= high_count + 1;
        end
    end

    a_de_per_line: assert property (@(posedge clock_50) disable iff (!reset_n)
        geometry_on && de_q && !lcd_de |-> de_ticks == `PANEL_H_ACTIVE)
    else report_error($sformatf("Error: frame_geometry de ticks expected %0d actual %0d",
                                `PANEL_H_ACTIVE, $sampled(de_ticks)));

    a_hs_per_line: assert property (@(posedge clock_50) disable iff (!reset_n)
        geometry_on && !hs_q && lcd_hs_n |-> hs_ticks == `PANEL_H_SYNC)
    else report_error($sformatf("Error: frame_geometry hs ticks expected %0d actual %0d",
                                `PANEL_H_SYNC, $sampled(hs_ticks)));

    a_color_active: assert property (@(posedge clock_50) disable iff (!reset_n)
        lcd_de |-> lcd_red == red_q && lcd_green == green_q && lcd_blue == blue_q)
    else report_error($sformatf("Error: color_path expected %0h/%0h/%0h actual %0h/%0h/%0h",
                                $sampled(red_q), $sampled(green_q), $sampled(blue_q),
                                $sampled(lcd_red), $sampled(lcd_green),
                                $sampled(lcd_blue)));

    a_color_blank: assert property (@(posedge clock_50) disable iff (!reset_n)
        !lcd_de |-> lcd_red == '0 && lcd_green == '0 && lcd_blue == '0)
    else report_error($sformatf("Error: color_blank expected 0/0/0 actual %0h/%0h/%0h",
                                $sampled(lcd_red), $sampled(lcd_green),
                                $sampled(lcd_blue)));

    a_sync_forced: assert property (@(posedge clock_50) disable iff (!reset_n)
        force_q |-> lcd_hs_n && lcd_vs_n)
    else report_error($sformatf("Error: sync_override expected 1/1 actual %0d/%0d",
                                $sampled(lcd_hs_n), $sampled(lcd_vs_n)));

    a_button_level: assert property (@(posedge clock_50) disable iff (!reset_n)
        button_check |-> button_state == button_expect)
    else report_error($sformatf("Error: home_button expected %0d actual %0d",
                                $sampled(button_expect), $sampled(button_state)));

    initial begin
        int bounce_len;
        void'($urandom(32'h9543_9d7a));
        reset_n      = 1'b0;
        hs_force     = 1'b0;
        vs_force     = 1'b0;
        level        = '0;
        level_valid  = 1'b0;
        button_pin   = 1'b1;
        button_ack   = 1'b0;
        geometry_on  = 1'b0;
        pwm_window   = 1'b0;
        button_check = 1'b0;
        button_expect = 1'b0;
        repeat (8) @(negedge clock_50);
        assert (!lcd_de && lcd_hs_n)
        else report_error($sformatf(
            "Error: reset_state expected de=0 hs_n=1 actual de=%0d hs_n=%0d",
            lcd_de, lcd_hs_n));
        reset_n = 1'b1;

        // One full frame between two next_frame pulses.
        wait_frame_start("frame_geometry");
        geometry_on = 1'b1;
        wait_frame_start("frame_geometry");
        check_count("frame_geometry active lines", `PANEL_V_ACTIVE, active_lines);
        check_count("frame_geometry vs ticks", `PANEL_V_SYNC * `PANEL_H_TOTAL, vs_ticks);
        geometry_on = 1'b0;

        hs_force = 1'b1;
        vs_force = 1'b1;
        wait_frame_start("sync_override");
        hs_force = 1'b0;
        vs_force = 1'b0;

        measure_backlight("backlight_default", PWM_PERIOD);
        level       = 10'd250;
        level_valid = 1'b1;
        repeat (4) @(negedge clock_50);
        measure_backlight("backlight_250", 62500);
        level = 10'd0;
        repeat (4) @(negedge clock_50);
        measure_backlight("backlight_0", 0);

        // Short bounces must not reach the host.
        button_check = 1'b1;
        repeat (6) begin
            button_pin = 1'b0;
            bounce_len = $urandom_range(999, 1);
            repeat (bounce_len) @(negedge clock_50);
            button_pin = 1'b1;
            bounce_len = $urandom_range(999, 1);
            repeat (bounce_len) @(negedge clock_50);
        end
        repeat (`DEBOUNCE_CYCLES + 16) @(negedge clock_50);
        button_check = 1'b0;
        button_pin = 1'b0;
        wait_button(1'b1, `DEBOUNCE_CYCLES + 16, "button_press");
        button_expect = 1'b1;
        button_check  = 1'b1;
        button_pin    = 1'b1;
        repeat (2 * `DEBOUNCE_CYCLES) @(negedge clock_50);
        button_check = 1'b0;
        button_ack   = 1'b1;
        wait_button(1'b0, `DEBOUNCE_CYCLES + 8, "button_release");
        button_ack = 1'b0;
        repeat (4) @(negedge clock_50);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* hdl/panel_top.sv */
// ####################################################################
// Panel top level: timing, output stage, backlight and home button.
// ####################################################################
`timescale 1ns/1ps

module panel_top (
    input  logic              clock_50,
    input  logic              reset_n,
    input  panel_pkg::color_t red,
    input  panel_pkg::color_t green,
    input  panel_pkg::color_t blue,
    input  logic              hs_force,
    input  logic              vs_force,
    input  panel_pkg::level_t level,
    input  logic              level_valid,
    input  logic              button_pin,
    input  logic              button_ack,
    output panel_pkg::coord_t lcd_x,
    output panel_pkg::coord_t lcd_y,
    output logic              next_frame,
    output logic              lcd_clock,
    output logic              lcd_de,
    output logic              lcd_hs_n,
    output logic              lcd_vs_n,
    output logic              lcd_backlight,
    output panel_pkg::color_t lcd_red,
    output panel_pkg::color_t lcd_green,
    output panel_pkg::color_t lcd_blue,
    output logic              button_state
);

    logic lcd_tick;
    logic timing_de;
    logic timing_hs_n;
    logic timing_vs_n;
    logic backlight;

    panel_timing u_timing (
        .clock_50    (clock_50),
        .reset_n     (reset_n),
        .lcd_tick    (lcd_tick),
        .lcd_x       (lcd_x),
        .lcd_y       (lcd_y),
        .timing_de   (timing_de),
        .timing_hs_n (timing_hs_n),
        .timing_vs_n (timing_vs_n),
        .next_frame  (next_frame)
    );

    backlight_pwm u_backlight (
        .clock_50    (clock_50),
        .reset_n     (reset_n),
        .level       (level),
        .level_valid (level_valid),
        .backlight   (backlight)
    );

    // Colors arrive from the external frame source, same clock as lcd_x/lcd_y.
    panel_output u_output (
        .clock_50      (clock_50),
        .reset_n       (reset_n),
        .lcd_tick      (lcd_tick),
        .timing_de     (timing_de),
        .timing_hs_n   (timing_hs_n),
        .timing_vs_n   (timing_vs_n),
        .hs_force      (hs_force),
        .vs_force      (vs_force),
        .backlight     (backlight),
        .red           (red),
        .green         (green),
        .blue          (blue),
        .lcd_clock     (lcd_clock),
        .lcd_de        (lcd_de),
        .lcd_hs_n      (lcd_hs_n),
        .lcd_vs_n      (lcd_vs_n),
        .lcd_backlight (lcd_backlight),
        .lcd_red       (lcd_red),
        .lcd_green     (lcd_green),
        .lcd_blue      (lcd_blue)
    );

    home_button u_button (
        .clock_50     (clock_50),
        .reset_n      (reset_n),
        .button_pin   (button_pin),
        .button_ack   (button_ack),
        .button_state (button_state)
    );

endmodule

/* hdl/panel_output.sv */
// ####################################################################
// Registered panel pins: blanking, sync overrides and backlight.
// ####################################################################
`timescale 1ns/1ps

module panel_output (
    input  logic              clock_50,
    input  logic              reset_n,
    input  logic              lcd_tick,
    input  logic              timing_de,
    input  logic              timing_hs_n,
    input  logic              timing_vs_n,
    input  logic              hs_force,
    input  logic              vs_force,
    input  logic              backlight,
    input  panel_pkg::color_t red,
    input  panel_pkg::color_t green,
    input  panel_pkg::color_t blue,
    output logic              lcd_clock,
    output logic              lcd_de,
    output logic              lcd_hs_n,
    output logic              lcd_vs_n,
    output logic              lcd_backlight,
    output panel_pkg::color_t lcd_red,
    output panel_pkg::color_t lcd_green,
    output panel_pkg::color_t lcd_blue
);

    // All pins leave from flops so they switch together.
    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            lcd_clock     <= 1'b0;
            lcd_de        <= 1'b0;
            lcd_hs_n      <= 1'b1;
            lcd_vs_n      <= 1'b1;
            lcd_backlight <= 1'b0;
            lcd_red       <= '0;
            lcd_green     <= '0;
            lcd_blue      <= '0;
        end else begin
            lcd_clock     <= lcd_tick;
            lcd_de        <= timing_de;
            // Force bits park the sync lines high.
            lcd_hs_n      <= hs_force | timing_hs_n;
            lcd_vs_n      <= vs_force | timing_vs_n;
            lcd_backlight <= backlight;
            // Black outside the visible area.
            lcd_red       <= timing_de ? red : '0;
            lcd_green     <= timing_de ? green : '0;
            lcd_blue      <= timing_de ? blue : '0;
        end
    end

endmodule

/* hdl/home_button.sv */
// ####################################################################
// Home button: synchronizer, debouncer and host handshake register.
// ####################################################################
`timescale 1ns/1ps
`include "panel_settings.svh"

module home_button (
    input  logic clock_50,
    input  logic reset_n,
    input  logic button_pin,
    input  logic button_ack,
    output logic button_state
);

    logic        pin_meta;
    logic        pin_sync;
    logic        raw_pressed;
    logic        debounced;
    logic [15:0] stable_count;

    // Pin is pulled up, so idle reads high.
    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            pin_meta <= 1'b1;
            pin_sync <= 1'b1;
        end else begin
            pin_meta <= button_pin;
            pin_sync <= pin_meta;
        end
    end

    // Button is active low.
    assign raw_pressed = ~pin_sync;

    // Count clocks the raw level differs from the debounced one.
    // A bounce back to the old level restarts the count.
    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            stable_count <= '0;
            debounced    <= 1'b0;
        end else if (raw_pressed == debounced) begin
            stable_count <= '0;
        end else if (stable_count == 16'(`DEBOUNCE_CYCLES - 1)) begin
            stable_count <= '0;
            debounced    <= raw_pressed;
        end else begin
            stable_count <= stable_count + 16'd1;
        end
    end

    // Hold the reported state until the host has copied it to button_ack.
    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            button_state <= 1'b0;
        end else if (button_ack == button_state) begin
            button_state <= debounced;
        end
    end

    // The host only moves button_ack by copying button_state.
    a_ack_copies_state: assert property (
        @(posedge clock_50) disable iff (!reset_n)
        $changed(button_ack) |-> (button_ack == button_state)
    ) else $error("button_ack changed without copying button_state");

endmodule

/* hdl/backlight_pwm.sv */
// ####################################################################
// Backlight PWM: prescaler and duty-cycle step counter.
// ####################################################################
`timescale 1ns/1ps
`include "panel_settings.svh"

module backlight_pwm (
    input  logic              clock_50,
    input  logic              reset_n,
    input  panel_pkg::level_t level,
    input  logic              level_valid,
    output logic              backlight
);

    logic [7:0]        prescale_count;
    logic              step_en;
    panel_pkg::level_t step;
    panel_pkg::level_t level_eff;

    assign step_en = (prescale_count == 8'(`BACKLIGHT_PRESCALE - 1));

    // Full brightness until the host supplies a level.
    assign level_eff = level_valid ? level : panel_pkg::level_t'(`BACKLIGHT_MAX);

    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            prescale_count <= '0;
        end else if (step_en) begin
            prescale_count <= '0;
        end else begin
            prescale_count <= prescale_count + 8'd1;
        end
    end

    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            step <= '0;
        end else if (step_en) begin
            if (step == panel_pkg::level_t'(`BACKLIGHT_MAX - 1)) begin
                step <= '0;
            end else begin
                step <= step + 10'd1;
            end
        end
    end

    // Level 0 never fires, level 1000 never drops.
    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            backlight <= 1'b0;
        end else begin
            backlight <= (step < level_eff);
        end
    end

    a_level_in_range: assert property (
        @(posedge clock_50) disable iff (!reset_n)
        level_valid |-> (level <= panel_pkg::level_t'(`BACKLIGHT_MAX))
    ) else $error("backlight level %0d above maximum", level);

endmodule

/* hdl/panel_timing.sv */
// ####################################################################
// Pixel tick, scan counters and sync/enable decode for the panel.
// ####################################################################
`timescale 1ns/1ps
`include "panel_settings.svh"

module panel_timing (
    input  logic              clock_50,
    input  logic              reset_n,
    output logic              lcd_tick,
    output panel_pkg::coord_t lcd_x,
    output panel_pkg::coord_t lcd_y,
    output logic              timing_de,
    output logic              timing_hs_n,
    output logic              timing_vs_n,
    output logic              next_frame
);

    logic line_end;
    logic frame_end;

    assign line_end  = (lcd_x == panel_pkg::coord_t'(`PANEL_H_TOTAL - 1));
    assign frame_end = (lcd_y == panel_pkg::coord_t'(`PANEL_V_TOTAL - 1));

    // Half of clock_50, so 25 MHz.
    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            lcd_tick <= 1'b0;
        end else begin
            lcd_tick <= ~lcd_tick;
        end
    end

    // Scan position, one step per pixel tick.
    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            lcd_x <= '0;
            lcd_y <= '0;
        end else if (lcd_tick) begin
            if (line_end) begin
                lcd_x <= '0;
                if (frame_end) begin
                    lcd_y <= '0;
                end else begin
                    lcd_y <= lcd_y + 10'd1;
                end
            end else begin
                lcd_x <= lcd_x + 10'd1;
            end
        end
    end

    assign timing_de = (lcd_x < panel_pkg::coord_t'(`PANEL_H_ACTIVE)) &&
                       (lcd_y < panel_pkg::coord_t'(`PANEL_V_ACTIVE));

    // Sync pulses sit right after the front porch.
    assign timing_hs_n =
        !((lcd_x >= panel_pkg::coord_t'(`PANEL_H_ACTIVE + `PANEL_H_FRONT)) &&
          (lcd_x < panel_pkg::coord_t'(`PANEL_H_ACTIVE + `PANEL_H_FRONT + `PANEL_H_SYNC)));
    assign timing_vs_n =
        !((lcd_y >= panel_pkg::coord_t'(`PANEL_V_ACTIVE + `PANEL_V_FRONT)) &&
          (lcd_y < panel_pkg::coord_t'(`PANEL_V_ACTIVE + `PANEL_V_FRONT + `PANEL_V_SYNC)));

    // Last pixel of the last line.
    assign next_frame = line_end && frame_end;

    // Wrap logic must keep the scan inside the frame at all times.
    a_scan_in_frame: assert property (
        @(posedge clock_50) disable iff (!reset_n)
        (lcd_x < panel_pkg::coord_t'(`PANEL_H_TOTAL)) &&
        (lcd_y < panel_pkg::coord_t'(`PANEL_V_TOTAL))
    ) else $error("scan position outside frame: x=%0d y=%0d", lcd_x, lcd_y);

endmodule

/* hdl/panel_pkg.sv */
// ####################################################################
// Shared pixel, coordinate and backlight level types.
// ####################################################################
package panel_pkg;

    // One color channel.
    typedef logic [7:0] color_t;

    // Pixel column or line number, up to 1023.
    typedef logic [9:0] coord_t;

    // Backlight brightness, 0 (off) to 1000 (full).
    typedef logic [9:0] level_t;

endpackage

/* hdl/panel_settings.svh */
// ####################################################################
// Panel geometry, porch widths, backlight PWM and debounce constants.
// ####################################################################
`ifndef PANEL_SETTINGS_SVH
`define PANEL_SETTINGS_SVH

// Horizontal timing, in pixel ticks.
`define PANEL_H_ACTIVE 800
`define PANEL_H_FRONT 40
`define PANEL_H_SYNC 48
`define PANEL_H_BACK 88
`define PANEL_H_TOTAL (`PANEL_H_ACTIVE + `PANEL_H_FRONT + `PANEL_H_SYNC + `PANEL_H_BACK)

// Vertical timing, in lines.
`define PANEL_V_ACTIVE 480
`define PANEL_V_FRONT 13
`define PANEL_V_SYNC 3
`define PANEL_V_BACK 32
`define PANEL_V_TOTAL (`PANEL_V_ACTIVE + `PANEL_V_FRONT + `PANEL_V_SYNC + `PANEL_V_BACK)

// 50 MHz / 250 / 1000 gives a 200 Hz backlight period.
`define BACKLIGHT_PRESCALE 250
`define BACKLIGHT_MAX 1000

// One millisecond at 50 MHz.
`define DEBOUNCE_CYCLES 50000

`endif
